// File: hdl/rdmon_settings.svh
/*
 * Shared build settings for the read path monitor
 *   AXI ID, address and data widths
 *   Default unit and agent IDs for monitor packets
 *   Monitor packet queue depth
 */
`ifndef RDMON_SETTINGS_SVH
`define RDMON_SETTINGS_SVH

// AXI channel widths
`define RDMON_ID_W        8
`define RDMON_ADDR_W      32
`define RDMON_DATA_W      32

// Monitor packet source fields
`define RDMON_UNIT_ID     2     // 4-bit field in the packet
`define RDMON_AGENT_ID    20    // 8-bit field in the packet

`define RDMON_MONQ_DEPTH  2     // Entries ahead of the monitor bus

`endif

// File: hdl/rdmon_pkg.sv
/*
 * Types for the read path monitor
 *   AR and R channel payload structs
 *   Response, packet type and event code enums
 *   64-bit monitor bus packet
 */
`default_nettype none
`include "rdmon_settings.svh"

package rdmon_pkg;

    typedef struct packed {
        logic [`RDMON_ID_W-1:0]   id;
        logic [`RDMON_ADDR_W-1:0] addr;
        logic [7:0]               len;      // Beats minus one
        logic [2:0]               size;
        logic [1:0]               burst;
        logic [2:0]               prot;
    } ar_chan_t;

    typedef struct packed {
        logic [`RDMON_ID_W-1:0]   id;
        logic [`RDMON_DATA_W-1:0] data;
        logic [1:0]               resp;     // Holds a resp_e code
        logic                     last;
    } r_chan_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_EXOKAY = 2'b01,
        RESP_SLVERR = 2'b10,
        RESP_DECERR = 2'b11
    } resp_e;

    typedef enum logic [3:0] {
        PKT_ERROR   = 4'd0,
        PKT_COMPL   = 4'd1,
        PKT_TIMEOUT = 4'd2
    } pkt_type_e;

    typedef enum logic [3:0] {
        EVT_COMPL_OK     = 4'd0,
        EVT_RESP_SLVERR  = 4'd1,
        EVT_RESP_DECERR  = 4'd2,
        EVT_TIMEOUT_DATA = 4'd3
    } evt_code_e;

    // Monitor bus packet, top bit first
    typedef struct packed {
        pkt_type_e   pkt_type;
        evt_code_e   evt_code;
        logic [3:0]  unit_id;
        logic [7:0]  agent_id;
        logic [7:0]  txn_id;
        logic [3:0]  reserved;   // Always zero
        logic [31:0] payload;    // Beat count, or active count on timeout
    } mon_pkt_t;

endpackage

`default_nettype wire

// File: hdl/rd_skid_buffer.sv
/*
 * Two-entry valid/ready skid buffer
 * Registered ready, one cycle of latency, full rate under steady flow
 */
`default_nettype none

module rd_skid_buffer #(
    parameter int WIDTH = 8
) (
    input  logic             aclk,
    input  logic             rst_n,
    input  logic [WIDTH-1:0] in_data,
    input  logic             in_valid,
    output logic             in_ready,
    output logic [WIDTH-1:0] out_data,
    output logic             out_valid,
    input  logic             out_ready
);

    logic [WIDTH-1:0] mem [2];     // Entry pair
    logic             wr_ptr;
    logic             rd_ptr;
    logic [1:0]       count;       // 0..2 entries held
    logic [1:0]       count_next;
    logic             push;
    logic             pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 2'd1;
        end else if (pop && !push) begin
            count_next = count - 2'd1;
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            count    <= 2'd0;
            in_ready <= 1'b0;                     // Rises one cycle after reset
        end else begin
            if (push) wr_ptr <= ~wr_ptr;
            if (pop)  rd_ptr <= ~rd_ptr;
            count    <= count_next;
            in_ready <= (count_next != 2'd2);     // Accept while not full
        end
    end

    always_ff @(posedge aclk) begin
        if (push) mem[wr_ptr] <= in_data;
    end

    assign out_valid = (count != 2'd0);
    assign out_data  = mem[rd_ptr];               // Oldest entry

endmodule

`default_nettype wire

// File: hdl/axi4_slave_rd.sv
/*
 * AXI4 read slave core
 *   AR skid buffer toward the backend, R skid buffer back to the master
 *   Outstanding burst count and busy flag
 */
`default_nettype none

module axi4_slave_rd (
    input  logic               aclk,
    input  logic               rst_n,
    // Slave side
    input  rdmon_pkg::ar_chan_t s_ar,
    input  logic               s_arvalid,
    output logic               s_arready,
    output rdmon_pkg::r_chan_t s_r,
    output logic               s_rvalid,
    input  logic               s_rready,
    // Backend side
    output rdmon_pkg::ar_chan_t fub_ar,
    output logic               fub_arvalid,
    input  logic               fub_arready,
    input  rdmon_pkg::r_chan_t fub_r,
    input  logic               fub_rvalid,
    output logic               fub_rready,
    output logic               busy
);

    logic [7:0] outstanding;   // Bursts accepted but not finished

    // ------------------------------------------------------------
    // Channel buffers
    // ------------------------------------------------------------
    rd_skid_buffer #(.WIDTH($bits(rdmon_pkg::ar_chan_t))) u_ar_skid (
        .aclk     (aclk),        .rst_n     (rst_n),
        .in_data  (s_ar),        .in_valid  (s_arvalid),   .in_ready  (s_arready),
        .out_data (fub_ar),      .out_valid (fub_arvalid), .out_ready (fub_arready)
    );

    rd_skid_buffer #(.WIDTH($bits(rdmon_pkg::r_chan_t))) u_r_skid (
        .aclk     (aclk),        .rst_n     (rst_n),
        .in_data  (fub_r),       .in_valid  (fub_rvalid),  .in_ready  (fub_rready),
        .out_data (s_r),         .out_valid (s_rvalid),    .out_ready (s_rready)
    );

    // Up on slave AR, down on slave R last
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            outstanding <= 8'd0;
        end else begin
            case ({s_arvalid && s_arready, s_rvalid && s_rready && s_r.last})
                2'b10:   outstanding <= outstanding + 8'd1;
                2'b01:   outstanding <= outstanding - 8'd1;
                default: outstanding <= outstanding;    // None, or both at once
            endcase
        end
    end

    assign busy = fub_arvalid || s_rvalid || (outstanding != 8'd0);

endmodule

`default_nettype wire

// File: hdl/rd_txn_monitor.sv
/*
 * Read transaction monitor on the slave-side handshakes
 *   Completion, error-response and timeout event packets
 *   Active, transaction and error counters
 *   Timeout configuration conflict flag
 */
`default_nettype none

module rd_txn_monitor #(
    parameter int UNIT_ID  = 2,
    parameter int AGENT_ID = 20
) (
    input  logic                aclk,
    input  logic                rst_n,
    input  rdmon_pkg::ar_chan_t s_ar,
    input  logic                s_arvalid,
    input  logic                s_arready,
    input  rdmon_pkg::r_chan_t  s_r,
    input  logic                s_rvalid,
    input  logic                s_rready,
    input  logic                cfg_monitor_enable,
    input  logic                cfg_error_enable,
    input  logic                cfg_timeout_enable,
    input  logic [15:0]         cfg_timeout_cycles,
    output logic                evt_valid,
    output rdmon_pkg::mon_pkt_t evt_pkt,
    output logic [7:0]          active_transactions,
    output logic [31:0]         transaction_count,
    output logic [15:0]         error_count,
    output logic                cfg_conflict_error
);

    logic                ar_hs, r_hs, last_hs;
    logic                is_err;
    logic                to_hit;          // Age reached threshold this cycle
    logic                to_fired;        // Timeout sent, waiting for next beat
    logic [15:0]         age;
    logic [31:0]         beat_cnt;        // Beats since last rlast
    logic [7:0]          ar_id_q;         // Most recent AR id
    logic                emit;
    rdmon_pkg::mon_pkt_t pkt_d;

    assign ar_hs   = s_arvalid && s_arready;
    assign r_hs    = s_rvalid && s_rready;
    assign last_hs = r_hs && s_r.last;
    assign is_err  = (s_r.resp == rdmon_pkg::RESP_SLVERR) ||
                     (s_r.resp == rdmon_pkg::RESP_DECERR);

    assign cfg_conflict_error = cfg_timeout_enable && (cfg_timeout_cycles == 16'd0);

    // Never on an R beat, so never alongside a last-beat event
    assign to_hit = (active_transactions != 8'd0) && !r_hs && !to_fired &&
                    (cfg_timeout_cycles != 16'd0) && (age == cfg_timeout_cycles);

    assign emit = cfg_monitor_enable &&
                  ((last_hs && (!is_err || cfg_error_enable)) ||
                   (to_hit && cfg_timeout_enable));

    // ------------------------------------------------------------
    // Packet build
    // ------------------------------------------------------------
    always_comb begin
        pkt_d          = '0;
        pkt_d.unit_id  = 4'(UNIT_ID);
        pkt_d.agent_id = 8'(AGENT_ID);
        if (to_hit) begin
            pkt_d.pkt_type = rdmon_pkg::PKT_TIMEOUT;
            pkt_d.evt_code = rdmon_pkg::EVT_TIMEOUT_DATA;
            pkt_d.txn_id   = ar_id_q;
            pkt_d.payload  = {24'd0, active_transactions};
        end else begin
            pkt_d.txn_id   = 8'(s_r.id);
            pkt_d.payload  = beat_cnt + 32'd1;           // Includes the last beat
            case (s_r.resp)
                rdmon_pkg::RESP_SLVERR: begin
                    pkt_d.pkt_type = rdmon_pkg::PKT_ERROR;
                    pkt_d.evt_code = rdmon_pkg::EVT_RESP_SLVERR;
                end
                rdmon_pkg::RESP_DECERR: begin
                    pkt_d.pkt_type = rdmon_pkg::PKT_ERROR;
                    pkt_d.evt_code = rdmon_pkg::EVT_RESP_DECERR;
                end
                default: begin                           // OKAY and EXOKAY
                    pkt_d.pkt_type = rdmon_pkg::PKT_COMPL;
                    pkt_d.evt_code = rdmon_pkg::EVT_COMPL_OK;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            evt_valid           <= 1'b0;
            active_transactions <= 8'd0;
            transaction_count   <= 32'd0;
            error_count         <= 16'd0;
            beat_cnt            <= 32'd0;
            age                 <= 16'd0;
            to_fired            <= 1'b0;
        end else begin
            evt_valid <= emit;                           // Single-cycle pulse
            if (ar_hs && !last_hs)      active_transactions <= active_transactions + 8'd1;
            else if (last_hs && !ar_hs) active_transactions <= active_transactions - 8'd1;
            if (last_hs) transaction_count <= transaction_count + 32'd1;  // Any burst end
            if (last_hs && is_err) error_count <= error_count + 16'd1;
            if (r_hs) beat_cnt <= last_hs ? 32'd0 : beat_cnt + 32'd1;
            // Age runs only while idle on R with bursts open
            if (r_hs) begin
                age      <= 16'd0;
                to_fired <= 1'b0;                        // Rearm
            end else begin
                if (active_transactions != 8'd0 && age != 16'hffff) age <= age + 16'd1;
                if (to_hit) to_fired <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (ar_hs) ar_id_q <= 8'(s_ar.id);
        if (emit)  evt_pkt <= pkt_d;
    end

endmodule

`default_nettype wire

// File: hdl/monbus_filter.sv
/*
 * Monitor bus filter and packet queue
 *   Packet-type and per-event mask drop
 *   Small FIFO onto the valid/ready monitor bus, drop count on overflow
 */
`default_nettype none
`include "rdmon_settings.svh"

module monbus_filter (
    input  logic                aclk,
    input  logic                rst_n,
    input  logic                evt_valid,
    input  rdmon_pkg::mon_pkt_t evt_pkt,
    input  logic [15:0]         cfg_pkt_mask,
    input  logic [15:0]         cfg_error_mask,
    input  logic [15:0]         cfg_compl_mask,
    input  logic [15:0]         cfg_timeout_mask,
    output logic                monbus_valid,
    input  logic                monbus_ready,
    output rdmon_pkg::mon_pkt_t monbus_packet,
    output logic [15:0]         dropped_count
);

    localparam int DEPTH = `RDMON_MONQ_DEPTH;
    localparam int PW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW    = $clog2(DEPTH + 1);

    rdmon_pkg::mon_pkt_t mem [DEPTH];
    logic [PW-1:0]       wr_ptr, rd_ptr;
    logic [CW-1:0]       count;
    logic [15:0]         evt_mask;        // Per-event mask for this packet type
    logic                keep, full, push, pop;

    always_comb begin
        case (evt_pkt.pkt_type)
            rdmon_pkg::PKT_ERROR:   evt_mask = cfg_error_mask;
            rdmon_pkg::PKT_COMPL:   evt_mask = cfg_compl_mask;
            rdmon_pkg::PKT_TIMEOUT: evt_mask = cfg_timeout_mask;
            default:                evt_mask = 16'h0000;
        endcase
    end

    assign keep = evt_valid && !cfg_pkt_mask[evt_pkt.pkt_type] && !evt_mask[evt_pkt.evt_code];
    assign full = (count == CW'(DEPTH));
    assign pop  = monbus_valid && monbus_ready;
    assign push = keep && (!full || pop);     // Slot frees up on the same edge

    // ------------------------------------------------------------
    // Queue control
    // ------------------------------------------------------------
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            wr_ptr        <= '0;
            rd_ptr        <= '0;
            count         <= '0;
            dropped_count <= 16'd0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + PW'(1);
            if (pop)  rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + PW'(1);
            if (push && !pop)      count <= count + CW'(1);
            else if (pop && !push) count <= count - CW'(1);
            if (keep && !push) dropped_count <= dropped_count + 16'd1;   // Lost to full
        end
    end

    always_ff @(posedge aclk) begin
        if (push) mem[wr_ptr] <= evt_pkt;
    end

    assign monbus_valid  = (count != '0);
    assign monbus_packet = mem[rd_ptr];

endmodule

`default_nettype wire

// File: hdl/axi4_slave_rd_mon.sv
/*
 * AXI4 read slave with transaction monitor
 *   Core read path, slave-side event monitor, monitor bus filter
 */
`default_nettype none
`include "rdmon_settings.svh"

module axi4_slave_rd_mon #(
    parameter int UNIT_ID  = `RDMON_UNIT_ID,
    parameter int AGENT_ID = `RDMON_AGENT_ID
) (
    input  logic                aclk,
    input  logic                rst_n,
    input  rdmon_pkg::ar_chan_t s_ar,
    input  logic                s_arvalid,
    output logic                s_arready,
    output rdmon_pkg::r_chan_t  s_r,
    output logic                s_rvalid,
    input  logic                s_rready,
    output rdmon_pkg::ar_chan_t fub_ar,
    output logic                fub_arvalid,
    input  logic                fub_arready,
    input  rdmon_pkg::r_chan_t  fub_r,
    input  logic                fub_rvalid,
    output logic                fub_rready,
    input  logic                cfg_monitor_enable,
    input  logic                cfg_error_enable,
    input  logic                cfg_timeout_enable,
    input  logic [15:0]         cfg_timeout_cycles,
    input  logic [15:0]         cfg_pkt_mask,
    input  logic [15:0]         cfg_error_mask,
    input  logic [15:0]         cfg_compl_mask,
    input  logic [15:0]         cfg_timeout_mask,
    output logic                monbus_valid,
    input  logic                monbus_ready,
    output rdmon_pkg::mon_pkt_t monbus_packet,
    output logic                busy,
    output logic [7:0]          active_transactions,
    output logic [31:0]         transaction_count,
    output logic [15:0]         error_count,
    output logic [15:0]         dropped_count,
    output logic                cfg_conflict_error
);

    logic                evt_valid;   // Monitor to filter
    rdmon_pkg::mon_pkt_t evt_pkt;

    axi4_slave_rd u_core (
        .aclk (aclk), .rst_n (rst_n),
        .s_ar (s_ar), .s_arvalid (s_arvalid), .s_arready (s_arready),
        .s_r  (s_r),  .s_rvalid  (s_rvalid),  .s_rready  (s_rready),
        .fub_ar (fub_ar), .fub_arvalid (fub_arvalid), .fub_arready (fub_arready),
        .fub_r  (fub_r),  .fub_rvalid  (fub_rvalid),  .fub_rready  (fub_rready),
        .busy (busy)
    );

    // Watches the slave side only
    rd_txn_monitor #(.UNIT_ID(UNIT_ID), .AGENT_ID(AGENT_ID)) u_mon (
        .aclk (aclk), .rst_n (rst_n),
        .s_ar (s_ar), .s_arvalid (s_arvalid), .s_arready (s_arready),
        .s_r  (s_r),  .s_rvalid  (s_rvalid),  .s_rready  (s_rready),
        .cfg_monitor_enable (cfg_monitor_enable), .cfg_error_enable (cfg_error_enable),
        .cfg_timeout_enable (cfg_timeout_enable), .cfg_timeout_cycles (cfg_timeout_cycles),
        .evt_valid (evt_valid), .evt_pkt (evt_pkt),
        .active_transactions (active_transactions), .transaction_count (transaction_count),
        .error_count (error_count), .cfg_conflict_error (cfg_conflict_error)
    );

    monbus_filter u_filter (
        .aclk (aclk), .rst_n (rst_n),
        .evt_valid (evt_valid), .evt_pkt (evt_pkt),
        .cfg_pkt_mask (cfg_pkt_mask), .cfg_error_mask (cfg_error_mask),
        .cfg_compl_mask (cfg_compl_mask), .cfg_timeout_mask (cfg_timeout_mask),
        .monbus_valid (monbus_valid), .monbus_ready (monbus_ready),
        .monbus_packet (monbus_packet), .dropped_count (dropped_count)
    );

endmodule

`default_nettype wire

// File: tb/axi4_slave_rd_mon_asserts.sv
/*
 * Bound handshake checks for the read slave with monitor
 *   Valid and payload hold under stall on AR, R and the monitor bus
 *   DUT-driven valids low in the cycle after reset
 */
`default_nettype none

module axi4_slave_rd_mon_asserts (
    input logic                aclk,
    input logic                rst_n,
    input rdmon_pkg::ar_chan_t s_ar,
    input logic                s_arvalid,
    input logic                s_arready,
    input rdmon_pkg::r_chan_t  s_r,
    input logic                s_rvalid,
    input logic                s_rready,
    input rdmon_pkg::ar_chan_t fub_ar,
    input logic                fub_arvalid,
    input logic                fub_arready,
    input rdmon_pkg::r_chan_t  fub_r,
    input logic                fub_rvalid,
    input logic                fub_rready,
    input rdmon_pkg::mon_pkt_t monbus_packet,
    input logic                monbus_valid,
    input logic                monbus_ready
);

    // ------------------------------------------------------------
    // Stall stability
    // ------------------------------------------------------------
    a_s_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        s_arvalid && !s_arready |=> s_arvalid && $stable(s_ar)) else $error("s_ar dropped");
    a_s_r_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        s_rvalid && !s_rready |=> s_rvalid && $stable(s_r)) else $error("s_r dropped");
    a_fub_ar_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        fub_arvalid && !fub_arready |=> fub_arvalid && $stable(fub_ar))
        else $error("fub_ar dropped");
    a_fub_r_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        fub_rvalid && !fub_rready |=> fub_rvalid && $stable(fub_r))
        else $error("fub_r dropped");
    a_mon_hold: assert property (@(posedge aclk) disable iff (!rst_n)
        monbus_valid && !monbus_ready |=> monbus_valid && $stable(monbus_packet))
        else $error("monbus packet dropped");

    // Outputs clear after a reset edge
    a_rst_valids: assert property (@(posedge aclk)
        !rst_n |=> !s_rvalid && !fub_arvalid && !monbus_valid)
        else $error("valid high after reset");

endmodule

bind axi4_slave_rd_mon axi4_slave_rd_mon_asserts u_asserts (
    .aclk (aclk), .rst_n (rst_n),
    .s_ar (s_ar), .s_arvalid (s_arvalid), .s_arready (s_arready),
    .s_r (s_r), .s_rvalid (s_rvalid), .s_rready (s_rready),
    .fub_ar (fub_ar), .fub_arvalid (fub_arvalid), .fub_arready (fub_arready),
    .fub_r (fub_r), .fub_rvalid (fub_rvalid), .fub_rready (fub_rready),
    .monbus_packet (monbus_packet), .monbus_valid (monbus_valid),
    .monbus_ready (monbus_ready)
);

`default_nettype wire

// File: tb/tb_axi4_slave_rd_mon.sv
/*
 * Testbench for the AXI4 read slave with monitor
 *   Row table of bursts, configs and masks applied in a loop
 *   Backend model, R beat checker, monitor packet scoreboard
 *   Cycle limit on the whole run
 */
`default_nettype none
`include "rdmon_settings.svh"

module tb_axi4_slave_rd_mon;

    localparam int NROWS  = 14;
    localparam int TO_CYC = 10;           // Timeout threshold for all rows

    typedef struct packed {
        logic [7:0]  id;
        logic [31:0] addr;
        logic [7:0]  len;
        logic [1:0]  resp;                // Last-beat response
        logic [7:0]  delay;               // Backend wait before first beat
        logic [15:0] pkt_mask;
        logic [15:0] err_mask;
        logic [15:0] compl_mask;
        logic [15:0] to_mask;
        logic [2:0]  en;                  // Monitor, error, timeout enables
        logic        hold;                // Keep monbus_ready low
    } row_t;

    logic aclk, rst_n;
    rdmon_pkg::ar_chan_t s_ar, fub_ar;
    rdmon_pkg::r_chan_t  s_r, fub_r;
    logic s_arvalid, s_arready, s_rvalid, s_rready;
    logic fub_arvalid, fub_arready, fub_rvalid, fub_rready;
    logic cfg_monitor_enable, cfg_error_enable, cfg_timeout_enable;
    logic [15:0] cfg_timeout_cycles, cfg_pkt_mask, cfg_error_mask;
    logic [15:0] cfg_compl_mask, cfg_timeout_mask;
    logic monbus_valid, monbus_ready, busy, cfg_conflict_error;
    rdmon_pkg::mon_pkt_t monbus_packet;
    logic [7:0]  active_transactions;
    logic [31:0] transaction_count;
    logic [15:0] error_count, dropped_count;

    row_t                rows [NROWS];
    rdmon_pkg::mon_pkt_t exp_q [$];       // Packets still to appear
    rdmon_pkg::ar_chan_t issued_ar;
    int seed, cycles, limit, cur, beat_idx, held_pending;
    int exp_txn, exp_err, exp_drop;

    axi4_slave_rd_mon u_dut (.*);

    initial begin
        aclk = 1'b0;
        forever #2 aclk = ~aclk;
    end

    task automatic fail_now(input string what);
        $display("%s", what);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] got);
        if (exp !== got) begin
            $display("Mismatch %s exp %h got %h", name, exp, got);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    // Run length guard
    initial begin
        cycles = 0;
        forever begin
            @(posedge aclk);
            cycles++;
            if (cycles >= limit) fail_now("Timeout: run did not finish within the cycle limit");
        end
    end

    // ------------------------------------------------------------
    // Scoreboard and R beat checker
    // ------------------------------------------------------------
    always @(posedge aclk) begin
        if (rst_n && monbus_valid && monbus_ready) begin
            if (exp_q.size() == 0) fail_now("Monitor bus sent a packet that was not expected");
            else check("monbus_packet", 64'(exp_q.pop_front()), 64'(monbus_packet));
        end
    end

    always @(posedge aclk) begin
        if (rst_n && s_rvalid && s_rready) begin
            check("s_r.id", 64'(rows[cur].id), 64'(s_r.id));
            check("s_r.data", 64'(rows[cur].addr + 32'(beat_idx)), 64'(s_r.data));
            check("s_r.resp", (beat_idx == int'(rows[cur].len)) ? 64'(rows[cur].resp) : 64'd0,
                  64'(s_r.resp));
            check("s_r.last", 64'(beat_idx == int'(rows[cur].len)), 64'(s_r.last));
            beat_idx = beat_idx + 1;
        end
    end

    // Random R back-pressure
    initial begin
        s_rready = 1'b0;
        forever begin
            @(negedge aclk);
            s_rready = rst_n && (($random(seed) & 3) != 0);  // 25% stall
        end
    end

    // Backend takes AR, waits, returns len+1 beats
    initial begin
        forever begin
            @(posedge aclk);
            if (rst_n && fub_arvalid && fub_arready) begin
                check("fub_ar", 64'(issued_ar), 64'(fub_ar));
                @(negedge aclk);
                repeat (int'(rows[cur].delay)) @(negedge aclk);
                for (int b = 0; b <= int'(rows[cur].len); b++) begin
                    fub_r.id   = rows[cur].id;
                    fub_r.data = rows[cur].addr + 32'(b);
                    fub_r.resp = (b == int'(rows[cur].len)) ? rows[cur].resp : 2'b00;
                    fub_r.last = (b == int'(rows[cur].len));
                    fub_rvalid = 1'b1;
                    @(posedge aclk);
                    while (!fub_rready) @(posedge aclk);
                    @(negedge aclk);
                end
                fub_rvalid = 1'b0;
            end
        end
    end

    // Queue a packet unless masked; models the 2-deep queue under hold
    task automatic expect_pkt(input row_t rw, input rdmon_pkg::pkt_type_e t,
                              input rdmon_pkg::evt_code_e c, input logic [31:0] payload);
        rdmon_pkg::mon_pkt_t p;
        logic [15:0]         m;
        m = (t == rdmon_pkg::PKT_ERROR) ? rw.err_mask :
            (t == rdmon_pkg::PKT_COMPL) ? rw.compl_mask : rw.to_mask;
        p          = '0;
        p.pkt_type = t;
        p.evt_code = c;
        p.unit_id  = 4'(`RDMON_UNIT_ID);
        p.agent_id = 8'(`RDMON_AGENT_ID);
        p.txn_id   = rw.id;
        p.payload  = payload;
        if (!rw.pkt_mask[t] && !m[c]) begin
            if (rw.hold && held_pending >= `RDMON_MONQ_DEPTH) begin
                exp_drop++;
            end else begin
                if (rw.hold) held_pending++;          // Waiting behind a low ready
                exp_q.push_back(p);
            end
        end
    endtask

    task automatic run_row(input int r);
        row_t rw;
        logic is_err;
        rw = rows[r];
        is_err = rw.resp[1];                          // SLVERR or DECERR
        @(negedge aclk);
        cur = r;
        beat_idx = 0;
        if (!rw.hold) held_pending = 0;
        {cfg_monitor_enable, cfg_error_enable, cfg_timeout_enable} = rw.en;
        cfg_pkt_mask = rw.pkt_mask;
        cfg_error_mask = rw.err_mask;
        cfg_compl_mask = rw.compl_mask;
        cfg_timeout_mask = rw.to_mask;
        monbus_ready = !rw.hold;
        if (int'(rw.delay) > TO_CYC && rw.en[2] && rw.en[0])
            expect_pkt(rw, rdmon_pkg::PKT_TIMEOUT, rdmon_pkg::EVT_TIMEOUT_DATA, 32'd1);
        if (rw.en[2] && (!is_err || rw.en[1])) begin
            if (rw.resp == 2'b10)
                expect_pkt(rw, rdmon_pkg::PKT_ERROR, rdmon_pkg::EVT_RESP_SLVERR, 32'(rw.len) + 1);
            else if (rw.resp == 2'b11)
                expect_pkt(rw, rdmon_pkg::PKT_ERROR, rdmon_pkg::EVT_RESP_DECERR, 32'(rw.len) + 1);
            else
                expect_pkt(rw, rdmon_pkg::PKT_COMPL, rdmon_pkg::EVT_COMPL_OK, 32'(rw.len) + 1);
        end
        exp_txn++;
        if (is_err) exp_err++;
        issued_ar = '{id: rw.id, addr: rw.addr, len: rw.len,
                      size: 3'd2, burst: 2'b01, prot: 3'd0};
        s_ar = issued_ar;
        s_arvalid = 1'b1;
        do @(posedge aclk); while (!s_arready);
        @(negedge aclk);
        s_arvalid = 1'b0;
        check("busy", 64'd1, 64'(busy));              // One burst open
        check("active_transactions", 64'd1, 64'(active_transactions));
        while (beat_idx <= int'(rw.len)) @(negedge aclk);
        repeat (3) @(negedge aclk);                   // Event plus queue write
        if (!rw.hold) while (exp_q.size() != 0) @(negedge aclk);
        check("transaction_count", 64'(exp_txn), 64'(transaction_count));
        check("error_count", 64'(exp_err), 64'(error_count));
        check("dropped_count", 64'(exp_drop), 64'(dropped_count));
        check("active_transactions", 64'd0, 64'(active_transactions));
        check("busy", 64'd0, 64'(busy));
    endtask

    initial begin
        seed = 32'h64ea;
        limit = 200;
        cur = 0;
        beat_idx = 0;
        held_pending = 0;
        exp_txn = 0;
        exp_err = 0;
        exp_drop = 0;
        rst_n = 1'b0;
        s_ar = '0;
        s_arvalid = 1'b0;
        fub_r = '0;
        fub_rvalid = 1'b0;
        fub_arready = 1'b1;
        cfg_monitor_enable = 1'b1;
        cfg_error_enable = 1'b1;
        cfg_timeout_enable = 1'b0;
        cfg_timeout_cycles = 16'(TO_CYC);
        cfg_pkt_mask = '0;
        cfg_error_mask = '0;
        cfg_compl_mask = '0;
        cfg_timeout_mask = '0;
        monbus_ready = 1'b1;
        //            id     addr      len resp  dly pkt    err    compl  to     en    hold
        rows[0]  = '{8'h01, 32'h1000, 8'd3, 2'd0, 8'd0,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b0};
        rows[1]  = '{8'h02, 32'h2000, 8'd0, 2'd1, 8'd2,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b0};
        rows[2]  = '{8'h03, 32'h3000, 8'd1, 2'd2, 8'd1,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b0};
        rows[3]  = '{8'h04, 32'h4000, 8'd2, 2'd3, 8'd0,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b0};
        rows[4]  = '{8'h05, 32'h5000, 8'd1, 2'd2, 8'd0,  16'h0, 16'h0, 16'h0, 16'h0, 3'b100, 1'b0};
        rows[5]  = '{8'h06, 32'h6000, 8'd2, 2'd0, 8'd30, 16'h0, 16'h0, 16'h0, 16'h0, 3'b111, 1'b0};
        rows[6]  = '{8'h07, 32'h7000, 8'd1, 2'd0, 8'd0,  16'h2, 16'h0, 16'h0, 16'h0, 3'b110, 1'b0};
        rows[7]  = '{8'h08, 32'h8000, 8'd0, 2'd3, 8'd0,  16'h0, 16'h4, 16'h0, 16'h0, 3'b110, 1'b0};
        rows[8]  = '{8'h09, 32'h9000, 8'd2, 2'd2, 8'd0,  16'h0, 16'h4, 16'h0, 16'h0, 3'b110, 1'b0};
        rows[9]  = '{8'h0a, 32'ha000, 8'd1, 2'd0, 8'd35, 16'h0, 16'h0, 16'h0, 16'h8, 3'b111, 1'b0};
        rows[10] = '{8'h0b, 32'hb000, 8'd1, 2'd0, 8'd0,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b1};
        rows[11] = '{8'h0c, 32'hc000, 8'd0, 2'd0, 8'd1,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b1};
        rows[12] = '{8'h0d, 32'hd000, 8'd3, 2'd0, 8'd0,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b1};
        rows[13] = '{8'h0e, 32'he000, 8'd0, 2'd0, 8'd0,  16'h0, 16'h0, 16'h0, 16'h0, 3'b110, 1'b0};
        for (int r = 0; r < NROWS; r++) limit += 8 * (int'(rows[r].len) + 1 + int'(rows[r].delay));
        repeat (4) @(negedge aclk);
        rst_n = 1'b1;
        // Zero threshold with timeouts on is a config conflict
        @(negedge aclk);
        cfg_timeout_enable = 1'b1;
        cfg_timeout_cycles = 16'd0;
        @(posedge aclk);
        check("cfg_conflict_error", 64'd1, 64'(cfg_conflict_error));
        @(negedge aclk);
        cfg_timeout_cycles = 16'(TO_CYC);
        @(posedge aclk);
        check("cfg_conflict_error", 64'd0, 64'(cfg_conflict_error));
        for (int r = 0; r < NROWS; r++) run_row(r);
        check("dropped_count", 64'd1, 64'(dropped_count));
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
+incdir+hdl
hdl/rdmon_pkg.sv
hdl/rd_skid_buffer.sv
hdl/axi4_slave_rd.sv
hdl/rd_txn_monitor.sv
hdl/monbus_filter.sv
hdl/axi4_slave_rd_mon.sv
tb/axi4_slave_rd_mon_asserts.sv
tb/tb_axi4_slave_rd_mon.sv

// File: Makefile
# Verilator build and run for the AXI4 read slave with monitor

VERILATOR ?= verilator
TOP       ?= tb_axi4_slave_rd_mon
FLIST     ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
JOBS      ?= 4

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
